/* bench/link_cases.hex */
// per case, line 1: ch1 word1..3, ch2 word1..3
// line 2: delay 1to2, delay 2to1, ready stall level (0 none .. 4 half), status ch1, status ch2
// case 0, shortest link
11111111 22222222 33333333 aaaa0001 aaaa0002 aaaa0003
00000001 00000001 00000000 00000003 00000003
// case 1
0badf00d 12345678 9abcdef0 cafe0001 cafe0002 cafe0003
00000004 00000007 00000000 0000001f 00000000
// case 2
deadbeef 01020304 a5a5a5a5 5a5a5a5a 10203040 feedface
00000002 00000003 00000004 00000003 00000013
// case 3
00000001 00000002 00000004 80000000 40000000 20000000
00000008 00000001 00000002 00000008 00000003
// case 4
00000000 ffffffff 00000000 ffffffff 00000000 ffffffff
00000005 00000005 00000000 0000000c 00000011
// case 5
13579bdf 2468ace0 0f0f0f0f f0f0f0f0 76543210 fedcba98
00000003 00000006 00000003 00000003 00000003
// case 6
c0ffee00 c0ffee01 c0ffee02 b00b0000 b00b0001 b00b0002
0000000a 00000002 00000001 0000001e 00000001
// case 7
7fffffff 80000001 00ff00ff ff00ff00 3c3c3c3c c3c3c3c3
00000001 0000000c 00000004 00000003 0000001f

/* src.f */
hdl/link_test_pkg.sv
hdl/frame_sender.sv
hdl/rx_capture.sv
hdl/latency_timer.sv
hdl/io_regs.sv
hdl/link_test_top.sv
bench/tb_link_test.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_link_test -f src.f -o sim_link_test > build.log 2>&1 \
	&& ./obj_dir/sim_link_test > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

/* bench/tb_link_test.sv */
`default_nettype none

module tb_link_test import link_test_pkg::*; ();

	localparam int N_CASES      = 8;
	localparam int CASE_WORDS   = 11;   // six data words, two delays, stall, two status
	localparam int WATCH_CYCLES = N_CASES * 200;

	logic               io_clk     = 1'b0;
	logic               rst        = 1'b1;
	logic               io_sel     = 1'b0;
	logic               io_sync    = 1'b0;
	addr_t              io_addr    = '0;
	logic               io_rd_en   = 1'b0;
	logic               io_wr_en   = 1'b0;
	word_t              io_wr_data = '0;
	word_t              io_rd_data;
	logic               io_rd_ack;
	wire link_beat_t [1:0] tx_beat;        // [0] is channel 1
	wire logic [1:0]    tx_valid;
	logic [1:0]         tx_ready    = '1;
	link_beat_t [1:0]   rx_beat     = '0;
	logic [1:0]         rx_valid    = '0;
	link_status_t [1:0] link_status = '0;

	word_t      cases_mem [N_CASES*CASE_WORDS];
	word_t      cur_words [2][FRAME_WORDS];   // frame loaded per channel
	int         delay [2] = '{1, 1};          // link cycles, channel to the other one
	logic [2:0] stall_lvl = '0;               // 0 keeps ready high
	int         case_num  = 0;
	int         seed      = 32'h062ae272;
	int         errors    = 0;
	int         tests_bad = 0;

	// link model state
	int         cyc             = 0;
	int         seen_case       = 0;
	int         tx_cnt [2]      = '{0, 0};
	int         rx_cnt [2]      = '{0, 0};
	int         first_valid [2] = '{-1, -1};   // edge that first saw tx valid
	int         first_xfer [2]  = '{-1, -1};
	logic       rdy_at_rx [2][FRAME_WORDS];    // own tx ready at each capture
	logic [1:0] prev_stall      = '0;
	link_beat_t [1:0] prev_beat;
	link_beat_t sched_beat [2][32];            // delay line slots, by cycle
	logic [1:0][31:0] sched_valid = '0;
	logic       ack_exp = 1'b0;

	link_test_top #(.COUNT_W(DEFAULT_COUNT_W)) i_link_test_top (
		.io_clk, .rst, .io_sel, .io_sync, .io_addr, .io_rd_en, .io_wr_en, .io_wr_data,
		.io_rd_data, .io_rd_ack,
		.tx_beat_1(tx_beat[0]), .tx_beat_2(tx_beat[1]),
		.tx_valid_1(tx_valid[0]), .tx_valid_2(tx_valid[1]),
		.tx_ready_1(tx_ready[0]), .tx_ready_2(tx_ready[1]),
		.rx_beat_1(rx_beat[0]), .rx_beat_2(rx_beat[1]),
		.rx_valid_1(rx_valid[0]), .rx_valid_2(rx_valid[1]),
		.link_status_1(link_status[0]), .link_status_2(link_status[1])
	);

	always #20 io_clk = ~io_clk;   // 40 unit period

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got == exp) else begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// link model, ack monitor and tx checks
	always @(posedge io_clk) begin
		int   slot;
		int   dst;
		int   r;
		logic rdy;
		if (!rst) begin
			assert (io_rd_ack == ack_exp) else begin
				$display("[FAIL] io_rd_ack got %h expected %h", io_rd_ack, ack_exp);
				errors++;
			end
		end
		ack_exp = !rst && io_sync && io_sel && io_rd_en;   // ack one edge later
		cyc++;
		if (case_num != seen_case) begin   // new case, fresh counters
			seen_case = case_num;
			for (int ch = 0; ch < 2; ch++) begin
				tx_cnt[ch]      = 0;
				rx_cnt[ch]      = 0;
				first_valid[ch] = -1;
				first_xfer[ch]  = -1;
			end
		end
		for (int ch = 0; ch < 2; ch++) begin
			dst = 1 - ch;
			if (prev_stall[ch]) begin   // stalled beat must still be there
				assert (tx_valid[ch]) else begin
					$display("channel %0d dropped valid during a stall", ch + 1);
					errors++;
				end
				check_word($sformatf("tx_beat_%0d.data", ch + 1), tx_beat[ch].data,
					prev_beat[ch].data);
			end
			if (tx_valid[ch] && first_valid[ch] < 0) first_valid[ch] = cyc;
			if (tx_valid[ch] && tx_ready[ch]) begin
				if (first_xfer[ch] < 0) first_xfer[ch] = cyc;
				assert (tx_cnt[ch] < FRAME_WORDS) else begin
					$display("channel %0d sent a beat after its frame was complete", ch + 1);
					errors++;
				end
				if (tx_cnt[ch] < FRAME_WORDS) begin
					check_word($sformatf("tx_beat_%0d.data", ch + 1), tx_beat[ch].data,
						cur_words[ch][tx_cnt[ch]]);
					check_word($sformatf("tx_beat_%0d.keep", ch + 1),
						word_t'(tx_beat[ch].keep), 32'hf);
					check_word($sformatf("tx_beat_%0d.last", ch + 1),
						word_t'(tx_beat[ch].last), word_t'(tx_cnt[ch] == FRAME_WORDS - 1));
				end
				tx_cnt[ch]++;
				slot = (cyc + delay[ch] - 1) % 32;   // seen by the far side D edges on
				sched_valid[dst][slot] = 1'b1;
				sched_beat[dst][slot]  = tx_beat[ch];
			end
			prev_stall[ch] = tx_valid[ch] && !tx_ready[ch];
			prev_beat[ch]  = tx_beat[ch];
		end
		for (int ch = 0; ch < 2; ch++) begin
			rdy = 1'b1;
			if (stall_lvl != 3'd0) begin
				r   = $random(seed);
				rdy = (r[2:0] >= stall_lvl);
			end
			tx_ready[ch] <= rdy;
			slot = cyc % 32;
			rx_valid[ch] <= sched_valid[ch][slot];
			if (sched_valid[ch][slot]) begin
				rx_beat[ch] <= sched_beat[ch][slot];
				if (rx_cnt[ch] < FRAME_WORDS) rdy_at_rx[ch][rx_cnt[ch]] = rdy;
				rx_cnt[ch]++;
				sched_valid[ch][slot] = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// register bus
	task automatic bus_write(input addr_t addr, input word_t data);
		@(posedge io_clk);
		io_sel     <= 1'b1;
		io_wr_en   <= 1'b1;
		io_addr    <= addr;
		io_wr_data <= data;
		@(posedge io_clk);
		io_sel   <= 1'b0;
		io_wr_en <= 1'b0;
		@(negedge io_clk);
	endtask

	task automatic bus_read(input addr_t addr, output word_t data);
		@(posedge io_clk);
		io_sel   <= 1'b1;
		io_sync  <= 1'b1;
		io_rd_en <= 1'b1;
		io_addr  <= addr;
		@(posedge io_clk);
		io_sel   <= 1'b0;
		io_sync  <= 1'b0;
		io_rd_en <= 1'b0;
		@(negedge io_clk);   // data loaded at the last edge
		assert (io_rd_ack) else begin
			$display("no read acknowledge for address %h", addr);
			errors++;
		end
		data = io_rd_data;
	endtask

	task automatic expect_read(input string name, input addr_t addr, input word_t exp);
		word_t got;
		bus_read(addr, got);
		check_word(name, got, exp);
	endtask

	task automatic check_reset_state();
		assert (tx_valid == 2'b00) else begin
			$display("tx valid high after reset");
			errors++;
		end
		expect_read("enable", ADDR_ENABLE, '0);
		expect_read("soft_rst", ADDR_SOFT_RST, '0);
		expect_read("lat_1to2", ADDR_LAT_1TO2, '0);
		expect_read("lat_2to1", ADDR_LAT_2TO1, '0);
		for (int i = 0; i < FRAME_WORDS; i++) begin
			expect_read($sformatf("ch1 data%0d", i), addr_t'(ADDR_CH1_DATA_BASE + i), '0);
			expect_read($sformatf("ch2 data%0d", i), addr_t'(ADDR_CH2_DATA_BASE + i), '0);
		end
		for (int i = 0; i < 2 * FRAME_WORDS; i++) begin
			expect_read($sformatf("ch1 rdbk%0d", i), addr_t'(ADDR_CH1_RDBK_BASE + i), '0);
			expect_read($sformatf("ch2 rdbk%0d", i), addr_t'(ADDR_CH2_RDBK_BASE + i), '0);
		end
	endtask

	//////////////////////////////////////////////////
	// one case from the file
	task automatic run_case(input int n);
		int    base;
		int    waited;
		addr_t data_base;
		addr_t rdbk_base;
		word_t exp_stat;
		base = n * CASE_WORDS;
		for (int ch = 0; ch < 2; ch++) begin
			for (int i = 0; i < FRAME_WORDS; i++) cur_words[ch][i] = cases_mem[base + ch * 3 + i];
		end
		delay[0]  = int'(cases_mem[base + 6]);
		delay[1]  = int'(cases_mem[base + 7]);
		stall_lvl = cases_mem[base + 8][2:0];
		@(posedge io_clk);
		link_status[0] <= link_status_t'(cases_mem[base + 9][4:0]);
		link_status[1] <= link_status_t'(cases_mem[base + 10][4:0]);
		@(negedge io_clk);
		bus_write(ADDR_SOFT_RST, 32'h1);   // clears both timers
		bus_write(ADDR_SOFT_RST, 32'h0);
		expect_read("lat_1to2", ADDR_LAT_1TO2, '0);
		expect_read("lat_2to1", ADDR_LAT_2TO1, '0);
		for (int ch = 0; ch < 2; ch++) begin
			data_base = (ch == 0) ? ADDR_CH1_DATA_BASE : ADDR_CH2_DATA_BASE;
			for (int i = 0; i < FRAME_WORDS; i++) bus_write(addr_t'(data_base + i), cur_words[ch][i]);
			for (int i = 0; i < FRAME_WORDS; i++) begin
				expect_read($sformatf("ch%0d data%0d", ch + 1, i), addr_t'(data_base + i),
					cur_words[ch][i]);
			end
		end
		case_num++;
		bus_write(ADDR_ENABLE, 32'h3);   // both frames at once
		waited = 0;
		while ((rx_cnt[0] < FRAME_WORDS || rx_cnt[1] < FRAME_WORDS) && waited < 150) begin
			@(negedge io_clk);
			waited++;
		end
		assert (waited < 150) else begin
			$display("frames did not cross the link within 150 cycles");
			errors++;
		end
		repeat (6) begin   // enable still set, no second frame
			@(negedge io_clk);
			assert (tx_valid == 2'b00) else begin
				$display("a sender started another frame without a new enable");
				errors++;
			end
		end
		check_word("ch1 transfers", word_t'(tx_cnt[0]), word_t'(FRAME_WORDS));
		check_word("ch2 transfers", word_t'(tx_cnt[1]), word_t'(FRAME_WORDS));
		bus_write(ADDR_ENABLE, 32'h0);
		for (int dst = 0; dst < 2; dst++) begin   // words came from the other channel
			rdbk_base = (dst == 0) ? ADDR_CH1_RDBK_BASE : ADDR_CH2_RDBK_BASE;
			for (int i = 0; i < FRAME_WORDS; i++) begin
				expect_read($sformatf("ch%0d word%0d", dst + 1, i + 1), addr_t'(rdbk_base + i),
					cur_words[1 - dst][i]);
			end
			for (int i = 0; i < FRAME_WORDS; i++) begin
				exp_stat = word_t'({rdy_at_rx[dst][i], 1'b1, (i == FRAME_WORDS - 1), 4'hf,
					link_status[dst]});
				expect_read($sformatf("ch%0d stat%0d", dst + 1, i + 1),
					addr_t'(rdbk_base + FRAME_WORDS + i), exp_stat);
			end
		end
		// stalls before the first transfer add to the link delay
		expect_read("lat_1to2", ADDR_LAT_1TO2,
			word_t'(delay[0] + first_xfer[0] - first_valid[0]));
		expect_read("lat_2to1", ADDR_LAT_2TO1,
			word_t'(delay[1] + first_xfer[1] - first_valid[1]));
	endtask

	task automatic report_test(input int num, input int errs_start);
		if (errors == errs_start) begin
			$display("test %0d ok", num);
		end else begin
			$display("test %0d: %0d errors", num, errors - errs_start);
			tests_bad++;
		end
	endtask

	initial begin
		int errs_start;
		$readmemh("bench/link_cases.hex", cases_mem);
		repeat (5) @(posedge io_clk);
		rst <= 1'b0;
		@(negedge io_clk);
		errs_start = errors;
		check_reset_state();
		report_test(0, errs_start);
		for (int n = 0; n < N_CASES; n++) begin
			errs_start = errors;
			run_case(n);
			report_test(n + 1, errs_start);
		end
		$display("summary: %0d run, %0d with errors, %0d check errors",
			N_CASES + 1, tests_bad, errors);
		if (errors == 0) $display("all tests passed");
		else $display("tests failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCH_CYCLES) @(posedge io_clk);
		$display("timeout, run stopped after %0d cycles", WATCH_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/link_test_top.sv */
`default_nettype none

module link_test_top import link_test_pkg::*; #(
	parameter int COUNT_W = DEFAULT_COUNT_W
) (
	input  wire logic         io_clk,
	input  wire logic         rst,
	// register bus
	input  wire logic         io_sel,
	input  wire logic         io_sync,
	input  wire addr_t        io_addr,
	input  wire logic         io_rd_en,
	input  wire logic         io_wr_en,
	input  wire word_t        io_wr_data,
	output word_t             io_rd_data,
	output logic              io_rd_ack,
	// link stream sides
	output link_beat_t        tx_beat_1,
	output link_beat_t        tx_beat_2,
	output logic              tx_valid_1,
	output logic              tx_valid_2,
	input  wire logic         tx_ready_1,
	input  wire logic         tx_ready_2,
	input  wire link_beat_t   rx_beat_1,
	input  wire link_beat_t   rx_beat_2,
	input  wire logic         rx_valid_1,
	input  wire logic         rx_valid_2,
	input  wire link_status_t link_status_1,
	input  wire link_status_t link_status_2
);

	logic [1:0]                enable;
	logic                      soft_rst;
	word_t [FRAME_WORDS-1:0]   frame_words_1;
	word_t [FRAME_WORDS-1:0]   frame_words_2;
	word_t [2*FRAME_WORDS-1:0] rdbk_1;
	word_t [2*FRAME_WORDS-1:0] rdbk_2;
	word_t                     lat_1to2;
	word_t                     lat_2to1;

	io_regs i_io_regs (
		.io_clk, .rst, .io_sel, .io_sync, .io_addr, .io_rd_en, .io_wr_en, .io_wr_data,
		.io_rd_data, .io_rd_ack, .enable, .soft_rst, .frame_words_1, .frame_words_2,
		.rdbk_1, .rdbk_2, .lat_1to2, .lat_2to1
	);

	//////////////////////////////////////////////////
	// senders
	frame_sender i_sender_1 (
		.io_clk, .rst, .soft_rst, .enable(enable[0]), .frame_words(frame_words_1),
		.tx_beat(tx_beat_1), .tx_valid(tx_valid_1), .tx_ready(tx_ready_1)
	);

	frame_sender i_sender_2 (
		.io_clk, .rst, .soft_rst, .enable(enable[1]), .frame_words(frame_words_2),
		.tx_beat(tx_beat_2), .tx_valid(tx_valid_2), .tx_ready(tx_ready_2)
	);

	// receive history
	rx_capture i_capture_1 (
		.io_clk, .rst, .rx_beat(rx_beat_1), .rx_valid(rx_valid_1),
		.link_status(link_status_1), .tx_ready(tx_ready_1), .rdbk(rdbk_1)
	);

	rx_capture i_capture_2 (
		.io_clk, .rst, .rx_beat(rx_beat_2), .rx_valid(rx_valid_2),
		.link_status(link_status_2), .tx_ready(tx_ready_2), .rdbk(rdbk_2)
	);

	//////////////////////////////////////////////////
	// cross channel latency
	latency_timer #(.COUNT_W(COUNT_W)) i_timer_1to2 (
		.io_clk, .rst, .soft_rst, .start(tx_valid_1), .stop(rx_valid_2), .count(lat_1to2)
	);

	latency_timer #(.COUNT_W(COUNT_W)) i_timer_2to1 (
		.io_clk, .rst, .soft_rst, .start(tx_valid_2), .stop(rx_valid_1), .count(lat_2to1)
	);

endmodule

`default_nettype wire

/* hdl/io_regs.sv */
`default_nettype none

module io_regs import link_test_pkg::*; (
	input  wire logic                        io_clk,
	input  wire logic                        rst,
	// register bus
	input  wire logic                        io_sel,
	input  wire logic                        io_sync,
	input  wire addr_t                       io_addr,
	input  wire logic                        io_rd_en,
	input  wire logic                        io_wr_en,
	input  wire word_t                       io_wr_data,
	output word_t                            io_rd_data,
	output logic                             io_rd_ack,
	// control out
	output logic [1:0]                       enable,
	output logic                             soft_rst,
	output word_t [FRAME_WORDS-1:0]          frame_words_1,
	output word_t [FRAME_WORDS-1:0]          frame_words_2,
	// status in
	input  wire word_t [2*FRAME_WORDS-1:0]   rdbk_1,
	input  wire word_t [2*FRAME_WORDS-1:0]   rdbk_2,
	input  wire word_t                       lat_1to2,
	input  wire word_t                       lat_2to1
);

	localparam int RDBK_WORDS = 2 * FRAME_WORDS;   // words then stats
	localparam addr_t [1:0] DATA_BASE = {ADDR_CH2_DATA_BASE, ADDR_CH1_DATA_BASE};
	localparam addr_t [1:0] RDBK_BASE = {ADDR_CH2_RDBK_BASE, ADDR_CH1_RDBK_BASE};

	word_t [1:0][FRAME_WORDS-1:0] data_q;   // [channel][word]
	word_t [1:0][RDBK_WORDS-1:0]  rdbk;
	logic                         wr_go;
	logic                         rd_go;
	logic                         rd_hit;   // address is mapped for reads
	word_t                        rd_mux;

	assign wr_go = io_sel & io_wr_en;
	assign rd_go = io_sel & io_rd_en;
	assign rdbk  = {rdbk_2, rdbk_1};

	assign frame_words_1 = data_q[0];
	assign frame_words_2 = data_q[1];

	//////////////////////////////////////////////////
	// writes
	always_ff @(posedge io_clk) begin
		if (rst) begin
			enable   <= '0;
			soft_rst <= 1'b0;
			data_q   <= '0;
		end else if (wr_go) begin
			if (io_addr == ADDR_ENABLE) enable <= io_wr_data[1:0];
			if (io_addr == ADDR_SOFT_RST) soft_rst <= io_wr_data[0];
			for (int ch = 0; ch < 2; ch++) begin
				for (int i = 0; i < FRAME_WORDS; i++) begin
					if (io_addr == addr_t'(DATA_BASE[ch] + i)) data_q[ch][i] <= io_wr_data;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// readback decode
	always_comb begin
		rd_hit = 1'b0;
		rd_mux = '0;
		if (io_addr == ADDR_ENABLE) begin
			rd_hit = 1'b1;
			rd_mux = word_t'(enable);
		end
		if (io_addr == ADDR_SOFT_RST) begin
			rd_hit = 1'b1;
			rd_mux = word_t'(soft_rst);
		end
		if (io_addr == ADDR_LAT_1TO2) begin
			rd_hit = 1'b1;
			rd_mux = lat_1to2;   // straight from the counter
		end
		if (io_addr == ADDR_LAT_2TO1) begin
			rd_hit = 1'b1;
			rd_mux = lat_2to1;
		end
		for (int ch = 0; ch < 2; ch++) begin
			for (int i = 0; i < FRAME_WORDS; i++) begin
				if (io_addr == addr_t'(DATA_BASE[ch] + i)) begin
					rd_hit = 1'b1;
					rd_mux = data_q[ch][i];
				end
			end
			for (int i = 0; i < RDBK_WORDS; i++) begin
				if (io_addr == addr_t'(RDBK_BASE[ch] + i)) begin
					rd_hit = 1'b1;
					rd_mux = rdbk[ch][i];   // captured words and stats
				end
			end
		end
	end

	// registered read data and ack, one cycle latency
	always_ff @(posedge io_clk) begin
		if (rst) begin
			io_rd_data <= '0;
			io_rd_ack  <= 1'b0;
		end else begin
			io_rd_ack <= io_sync & rd_go;
			if (rd_go && rd_hit) io_rd_data <= rd_mux;   // unmapped leaves old data
		end
	end

	// bus master never reads and writes in one access
	a_rd_wr_excl: assert property (@(posedge io_clk) disable iff (rst)
		io_sel |-> !(io_rd_en && io_wr_en));

endmodule

`default_nettype wire

/* hdl/latency_timer.sv */
`default_nettype none

module latency_timer import link_test_pkg::*; #(
	parameter int COUNT_W = DEFAULT_COUNT_W   // up to 32
) (
	input  wire logic io_clk,
	input  wire logic rst,
	input  wire logic soft_rst,
	input  wire logic start,   // first edge seeing this begins the count
	input  wire logic stop,    // first edge seeing this ends it
	output word_t     count
);

	typedef enum logic [1:0] {
		T_IDLE,     // waiting for start
		T_COUNT,    // one per edge
		T_FROZEN    // result held until reset
	} phase_t;

	phase_t             phase;
	logic [COUNT_W-1:0] cnt;
	logic               clr;

	assign clr = rst | soft_rst;

	always_ff @(posedge io_clk) begin
		if (clr) begin
			phase <= T_IDLE;
			cnt   <= '0;
		end else begin
			case (phase)
				T_IDLE: if (start) phase <= stop ? T_FROZEN : T_COUNT;   // start edge adds nothing
				T_COUNT: begin
					if (cnt != '1) cnt <= cnt + 1'b1;   // saturate instead of wrapping
					if (stop) phase <= T_FROZEN;       // stop edge still counts
				end
				T_FROZEN: phase <= T_FROZEN;
				default: phase <= T_IDLE;
			endcase
		end
	end

	assign count = word_t'(cnt);   // zero extend onto the bus

	// between resets the result only grows
	a_monotonic: assert property (@(posedge io_clk) disable iff (clr)
		!$past(clr) |-> count >= $past(count));

endmodule

`default_nettype wire

/* hdl/rx_capture.sv */
`default_nettype none

module rx_capture import link_test_pkg::*; (
	input  wire logic                      io_clk,
	input  wire logic                      rst,
	input  wire link_beat_t                rx_beat,
	input  wire logic                      rx_valid,      // no ready, every valid beat is taken
	input  wire link_status_t              link_status,
	input  wire logic                      tx_ready,      // same channel's tx side
	output word_t [2*FRAME_WORDS-1:0]      rdbk           // word1..3 then stat1..3
);

	word_t [FRAME_WORDS-1:0] words;   // [0] oldest, top index newest
	word_t [FRAME_WORDS-1:0] stats;   // snapshots, same order as words
	word_t                   snap;

	// status snapshot, 12 bits zero extended
	// tx_ready, rx_valid, last, keep, hard/soft/frame err, lane_up, channel_up
	assign snap = word_t'({tx_ready, rx_valid, rx_beat.last, rx_beat.keep, link_status});

	//////////////////////////////////////////////////
	// history shift, newest in at the top
	always_ff @(posedge io_clk) begin
		if (rst) begin
			words <= '0;
			stats <= '0;
		end else if (rx_valid) begin
			words <= {rx_beat.data, words[FRAME_WORDS-1:1]};   // drop the oldest
			stats <= {snap, stats[FRAME_WORDS-1:1]};
		end
	end

	assign rdbk = {stats, words};

endmodule

`default_nettype wire

/* hdl/frame_sender.sv */
`default_nettype none

module frame_sender import link_test_pkg::*; (
	input  wire logic                    io_clk,
	input  wire logic                    rst,
	input  wire logic                    soft_rst,     // held in idle while set
	input  wire logic                    enable,       // this channel's enable bit
	input  wire word_t [FRAME_WORDS-1:0] frame_words,  // [0] goes out first
	output link_beat_t                   tx_beat,
	output logic                         tx_valid,
	input  wire logic                    tx_ready
);

	localparam int IDX_W = $clog2(FRAME_WORDS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_WORDS - 1);

	sender_state_t    state;
	logic [IDX_W-1:0] idx;        // word now on the link
	logic [IDX_W-1:0] next_idx;   // word to load next
	logic             clr;
	logic             xfer;       // beat taken this edge
	logic             load;       // new beat into the output register

	assign clr      = rst | soft_rst;
	assign xfer     = tx_valid & tx_ready;
	assign next_idx = (state == IDLE) ? '0 : idx + 1'b1;
	assign load     = ((state == IDLE) && enable) || (xfer && (idx != LAST_IDX));
	assign tx_valid = (state == SEND);   // valid follows the state, no extra flop

	//////////////////////////////////////////////////
	// control
	always_ff @(posedge io_clk) begin
		if (clr) begin
			state <= IDLE;
			idx   <= '0;
		end else begin
			if (load) idx <= next_idx;
			case (state)
				IDLE: if (enable) state <= SEND;   // one frame per enable
				SEND: if (xfer && (idx == LAST_IDX)) state <= DONE;
				DONE: if (!enable) state <= IDLE;   // rearm only after enable drops
				default: state <= IDLE;
			endcase
		end
	end

	// beat payload, only moves on load so it holds through a stall
	always_ff @(posedge io_clk) begin
		if (rst) begin
			tx_beat <= '0;
		end else if (load) begin
			tx_beat.data <= frame_words[next_idx];
			tx_beat.keep <= '1;                       // full words only
			tx_beat.last <= (next_idx == LAST_IDX);   // last on third word
		end
	end

	// a stalled beat stays on the link until it is taken
	a_beat_hold: assert property (@(posedge io_clk) disable iff (clr)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat));

endmodule

`default_nettype wire

/* hdl/link_test_pkg.sv */
`default_nettype none

package link_test_pkg;

	//////////////////////////////////////////////////
	// widths
	typedef logic [31:0] word_t;   // bus and link data word
	typedef logic [15:0] addr_t;   // register address, top bits already consumed upstream
	typedef logic [3:0]  keep_t;   // byte valids

	// one beat on the link stream, 37 bits
	typedef struct packed {
		word_t data;
		keep_t keep;
		logic  last;   // marks the final word of a frame
	} link_beat_t;

	// link core status, msb first as it lands in the stat word
	typedef struct packed {
		logic hard_err;
		logic soft_err;
		logic frame_err;
		logic lane_up;
		logic channel_up;
	} link_status_t;

	typedef enum logic [1:0] {
		IDLE,   // waiting for the enable bit
		SEND,   // frame on the link
		DONE    // frame sent, wait for enable to drop
	} sender_state_t;

	//////////////////////////////////////////////////
	// register map
	localparam addr_t ADDR_LAT_1TO2      = 16'h0013;   // ch1 tx valid -> ch2 rx valid
	localparam addr_t ADDR_LAT_2TO1      = 16'h0014;   // ch2 tx valid -> ch1 rx valid
	localparam addr_t ADDR_ENABLE        = 16'h0020;   // bit 0 ch1, bit 1 ch2
	localparam addr_t ADDR_SOFT_RST      = 16'h0030;   // holds senders and timers
	localparam addr_t ADDR_CH1_DATA_BASE = 16'h0021;   // three words
	localparam addr_t ADDR_CH2_DATA_BASE = 16'h0031;
	localparam addr_t ADDR_CH1_RDBK_BASE = 16'h0024;   // word1..3 then stat1..3
	localparam addr_t ADDR_CH2_RDBK_BASE = 16'h0034;

	localparam int FRAME_WORDS     = 3;    // words per frame
	localparam int DEFAULT_COUNT_W = 32;   // latency counter width

endpackage

`default_nettype wire
